// File: verilog.f
hdl/capture_pkg.sv
hdl/sample_fifo.sv
hdl/block_scheduler.sv
hdl/bulk_memory.sv
hdl/capture_top.sv
test/clock_gen.sv
test/capture_tb.sv

// File: test/capture_tb.sv
module capture_tb;

   // generous bound on capture plus playback plus the quiet tail
   localparam int TIMEOUT = capture_pkg::FILL_WORDS * 40 * 4;

   logic                                write_clk;
   logic                                rst;
   logic                                start;
   logic                                in_valid;
   logic [capture_pkg::SAMPLE_W-1:0]    in_data;
   logic                                in_ready;
   logic                                out_valid;
   logic [capture_pkg::SAMPLE_W-1:0]    out_data;
   logic                                out_ready;
   logic                                filled;
   logic                                done;

   logic [capture_pkg::SAMPLE_W-1:0]    sent_q[$];   // every accepted sample in order
   logic [31:0]                         rng;
   logic                                stim_en;
   logic                                in_fire;
   logic                                started;
   logic                                out_stalled;
   logic [capture_pkg::SAMPLE_W-1:0]    stalled_data;
   logic                                done_seen;
   logic                                filled_seen;
   int                                  out_count;
   int                                  since_start;
   int                                  cycle;
   int                                  start_at;

   clock_gen #(
      .PERIOD (4)
   ) clk_gen (
      .clk (write_clk)
   );

   capture_top DUT (
      .write_clk (write_clk),
      .rst       (rst),
      .start     (start),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_ready (out_ready),
      .filled    (filled),
      .done      (done)
   );

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      abort_run();
   endtask

   task automatic report_error(input string msg);
      $display("%s", msg);
      abort_run();
   endtask

   task automatic check_idle_outputs(input string name);
      assert (!in_ready) else report_value({name, " in_ready"}, 0, in_ready);
      assert (!out_valid) else report_value({name, " out_valid"}, 0, out_valid);
      assert (!filled) else report_value({name, " filled"}, 0, filled);
      assert (!done) else report_value({name, " done"}, 0, done);
   endtask

   initial
   begin
      rst          = 1'b1;
      start        = 1'b0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b0;
      rng          = 32'd8;
      stim_en      = 1'b0;
      in_fire      = 1'b0;
      started      = 1'b0;
      out_stalled  = 1'b0;
      stalled_data = '0;
      done_seen    = 1'b0;
      filled_seen  = 1'b0;
      out_count    = 0;
      since_start  = 0;
      cycle        = 0;
      start_at     = 0;

      repeat (8) @(posedge write_clk);
      @(negedge write_clk);
      rst = 1'b0;
      rng = next_random(rng);
      start_at = 4 + (rng % 16);   // samples are offered for a while before start
      @(posedge write_clk);
      check_idle_outputs("after_reset");
      stim_en = 1'b1;

      while (!done)
         @(posedge write_clk);
      repeat (50) @(posedge write_clk);

      if (out_count == capture_pkg::FILL_WORDS && sent_q.size() >= capture_pkg::FILL_WORDS)
      begin
         $display("NO ERRORS");
         $finish;
      end
      else
         report_error("run ended without delivering every stored sample");
   end

   always @(negedge write_clk)
   begin
      if (stim_en)
      begin
         cycle++;
         start = (cycle == start_at);
         // a sample on offer stays put until the FIFO takes it
         if (!in_valid || in_fire)
         begin
            rng = next_random(rng);
            in_valid = (rng[1:0] != 2'b00);
            rng = next_random(rng);
            in_data = rng[capture_pkg::SAMPLE_W-1:0];
         end
         rng = next_random(rng);
         out_ready = (rng % 3 != 0);   // about one stall in three
      end
   end

   always @(posedge write_clk)
   begin
      if (rst)
         check_idle_outputs("reset");
      else
      begin
         // two synchronizer flops plus the capture_en register
         if (!started || since_start < 3)
            assert (!in_ready) else report_value("no_capture_before_start", 0, in_ready);
         else if (since_start == 3)
            assert (in_ready) else report_value("start_latency", 1, in_ready);
         if (started)
            since_start++;
         else if (start)
         begin
            started     = 1'b1;
            since_start = 1;
         end

         if (filled)
         begin
            assert (!in_ready) else report_value("end_of_capture", 0, in_ready);
            // the memory cannot be full before that many samples were taken in
            assert (sent_q.size() >= capture_pkg::FILL_WORDS)
               else report_value("filled_early", capture_pkg::FILL_WORDS, sent_q.size());
         end
         if (filled_seen)
            assert (filled) else report_value("filled_held", 1, filled);
         filled_seen = filled_seen || filled;

         in_fire = in_valid && in_ready;
         if (in_fire)
            sent_q.push_back(in_data);

         if (out_stalled)
         begin
            assert (out_valid) else report_error("out_valid dropped while out_ready was low");
            assert (out_data == stalled_data)
               else report_value("output_hold", stalled_data, out_data);
         end

         if (done && !done_seen)
         begin
            done_seen = 1'b1;
            assert (out_count == capture_pkg::FILL_WORDS)
               else report_value("completion_count", capture_pkg::FILL_WORDS, out_count);
         end
         if (done)
            assert (!out_valid) else report_value("quiet_after_done", 0, out_valid);

         if (out_valid && out_ready)
         begin
            // playback only starts once capture has ended
            assert (filled) else report_value("filled_before_playback", 1, filled);
            if (out_count >= capture_pkg::FILL_WORDS || out_count >= sent_q.size())
               report_error("output transfer beyond the stored samples");
            else
               assert (out_data == sent_q[out_count])
                  else report_value("data_order", sent_q[out_count], out_data);
            out_count++;
         end
         out_stalled  = out_valid && !out_ready;
         stalled_data = out_data;
      end
   end

   initial
   begin
      #(TIMEOUT);
      $display("timeout: the run did not finish within %0d time units", TIMEOUT);
      abort_run();
   end

endmodule

// File: test/clock_gen.sv
module clock_gen #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2) clk = ~clk;   // even duty cycle
   end

endmodule

// File: hdl/capture_top.sv
module capture_top (
   input  logic                                write_clk,
   input  logic                                rst,
   input  logic                                start,

   input  logic                                in_valid,
   input  logic [capture_pkg::SAMPLE_W-1:0]    in_data,
   output logic                                in_ready,

   output logic                                out_valid,
   output logic [capture_pkg::SAMPLE_W-1:0]    out_data,
   input  logic                                out_ready,

   output logic                                filled,
   output logic                                done
);

   logic                                capture_en;
   logic                                aq_wr_valid;
   logic                                aq_wr_ready;
   logic                                aq_rd_valid;
   logic                                aq_rd_ready;
   logic [capture_pkg::SAMPLE_W-1:0]    aq_rd_data;
   logic [capture_pkg::AQ_CNT_W-1:0]    aq_count;

   logic                                cmd_ready;
   logic                                cmd_enable;
   capture_pkg::mem_op_t                cmd_op;
   logic [capture_pkg::ADDR_W-1:0]      cmd_address;
   logic [capture_pkg::SAMPLE_W-1:0]    cmd_wdata;

   logic                                rd_valid;
   logic [capture_pkg::SAMPLE_W-1:0]    rd_data;
   logic                                tx_wr_ready;
   logic [capture_pkg::TX_CNT_W-1:0]    tx_count;

   // input handshake is closed outside the capture window
   assign aq_wr_valid = in_valid && capture_en;
   assign in_ready    = aq_wr_ready && capture_en;

   sample_fifo #(
      .DEPTH (capture_pkg::AQ_DEPTH)
   ) aq_fifo (
      .write_clk (write_clk),
      .rst       (rst),
      .wr_valid  (aq_wr_valid),
      .wr_ready  (aq_wr_ready),
      .wr_data   (in_data),
      .rd_valid  (aq_rd_valid),
      .rd_ready  (aq_rd_ready),
      .rd_data   (aq_rd_data),
      .count     (aq_count)
   );

   block_scheduler block_scheduler (
      .write_clk   (write_clk),
      .rst         (rst),
      .start       (start),
      .capture_en  (capture_en),
      .aq_rd_valid (aq_rd_valid),
      .aq_rd_ready (aq_rd_ready),
      .aq_rd_data  (aq_rd_data),
      .aq_count    (aq_count),
      .cmd_ready   (cmd_ready),
      .cmd_enable  (cmd_enable),
      .cmd_op      (cmd_op),
      .cmd_address (cmd_address),
      .cmd_wdata   (cmd_wdata),
      .tx_count    (tx_count),
      .rd_valid    (rd_valid),
      .filled      (filled),
      .done        (done)
   );

   bulk_memory bulk_memory (
      .write_clk   (write_clk),
      .rst         (rst),
      .cmd_enable  (cmd_enable),
      .cmd_op      (cmd_op),
      .cmd_address (cmd_address),
      .cmd_wdata   (cmd_wdata),
      .cmd_ready   (cmd_ready),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data)
   );

   // the read room rule keeps tx_wr_ready high whenever rd_valid arrives
   sample_fifo #(
      .DEPTH (capture_pkg::TX_DEPTH)
   ) tx_fifo (
      .write_clk (write_clk),
      .rst       (rst),
      .wr_valid  (rd_valid),
      .wr_ready  (tx_wr_ready),
      .wr_data   (rd_data),
      .rd_valid  (out_valid),
      .rd_ready  (out_ready),
      .rd_data   (out_data),
      .count     (tx_count)
   );

   a_tx_room: assert property (@(posedge write_clk) disable iff (rst)
      rd_valid |-> tx_wr_ready)
      else $error("transmit FIFO refused a read word");

endmodule

// File: hdl/bulk_memory.sv
module bulk_memory (
   input  logic                                write_clk,
   input  logic                                rst,

   input  logic                                cmd_enable,
   input  capture_pkg::mem_op_t                cmd_op,
   input  logic [capture_pkg::ADDR_W-1:0]      cmd_address,
   input  logic [capture_pkg::SAMPLE_W-1:0]    cmd_wdata,
   output logic                                cmd_ready,

   output logic                                rd_valid,
   output logic [capture_pkg::SAMPLE_W-1:0]    rd_data
);

   logic [capture_pkg::SAMPLE_W-1:0]          mem [capture_pkg::FILL_WORDS];
   logic [$clog2(capture_pkg::FILL_WORDS)-1:0] word_addr;
   logic                                      busy;
   logic                                      take;
   logic [capture_pkg::MEM_READ_LAT-1:0]      pipe_valid;
   logic [capture_pkg::SAMPLE_W-1:0]          pipe_data [capture_pkg::MEM_READ_LAT];

   assign word_addr = cmd_address[$clog2(capture_pkg::FILL_WORDS)-1:0];
   assign take      = cmd_enable && cmd_ready;
   assign cmd_ready = !busy;

   assign rd_valid = pipe_valid[capture_pkg::MEM_READ_LAT-1];
   assign rd_data  = pipe_data[capture_pkg::MEM_READ_LAT-1];

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         busy       <= 1'b0;
         pipe_valid <= '0;
      end
      else
      begin
         busy          <= take;   // one dead cycle after every accepted command
         pipe_valid[0] <= take && (cmd_op == capture_pkg::MEM_READ);
         for (int i = 1; i < capture_pkg::MEM_READ_LAT; i++)
            pipe_valid[i] <= pipe_valid[i-1];
      end
   end

   // data side of the read pipe runs freely, the valid bits qualify it
   always_ff @(posedge write_clk)
   begin
      if (take && (cmd_op == capture_pkg::MEM_WRITE))
         mem[word_addr] <= cmd_wdata;
      pipe_data[0] <= mem[word_addr];
      for (int i = 1; i < capture_pkg::MEM_READ_LAT; i++)
         pipe_data[i] <= pipe_data[i-1];
   end

   // the scheduler's pointers must stay inside the stored region
   a_addr_range: assert property (@(posedge write_clk) disable iff (rst)
      take |-> (cmd_address < capture_pkg::FILL_WORDS))
      else $error("memory command address out of range");

endmodule

// File: hdl/block_scheduler.sv
module block_scheduler (
   input  logic                                write_clk,
   input  logic                                rst,
   input  logic                                start,

   output logic                                capture_en,

   input  logic                                aq_rd_valid,
   output logic                                aq_rd_ready,
   input  logic [capture_pkg::SAMPLE_W-1:0]    aq_rd_data,
   input  logic [capture_pkg::AQ_CNT_W-1:0]    aq_count,

   input  logic                                cmd_ready,
   output logic                                cmd_enable,
   output capture_pkg::mem_op_t                cmd_op,
   output logic [capture_pkg::ADDR_W-1:0]      cmd_address,
   output logic [capture_pkg::SAMPLE_W-1:0]    cmd_wdata,

   input  logic [capture_pkg::TX_CNT_W-1:0]    tx_count,
   input  logic                                rd_valid,

   output logic                                filled,
   output logic                                done
);

   logic [1:0]                          start_sync;
   logic [capture_pkg::ADDR_W-1:0]      wr_ptr;
   logic [capture_pkg::ADDR_W-1:0]      rd_ptr;
   logic [capture_pkg::BLK_CNT_W-1:0]   blk_cnt;
   logic [capture_pkg::FLIGHT_W-1:0]    in_flight;
   logic [capture_pkg::TX_CNT_W:0]      tx_pending;
   capture_pkg::sched_state_t           state;
   logic                                cmd_idle;
   logic                                issue_write;
   logic                                issue_read;
   logic                                play_over;

   // the memory port is free only when nothing is waiting on it
   assign cmd_idle = cmd_ready && !cmd_enable;

   assign issue_write = (state == capture_pkg::CAPTURE_MOVE) && cmd_idle && aq_rd_valid;
   assign aq_rd_ready = issue_write;   // pop the word as its write command is registered

   // transmit fill plus words still coming back from the memory
   assign tx_pending = (capture_pkg::TX_CNT_W+1)'(tx_count)
                     + (capture_pkg::TX_CNT_W+1)'(in_flight);

   assign issue_read = (state == capture_pkg::PLAYBACK) && cmd_idle
                     && (rd_ptr < capture_pkg::FILL_WORDS)
                     && (tx_pending < capture_pkg::TX_HIGH);

   // done also waits for the transmit FIFO to drain
   assign play_over = (rd_ptr == capture_pkg::FILL_WORDS) && (in_flight == 0)
                    && (tx_count == 0);

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
         start_sync <= 2'b00;
      else
         start_sync <= {start_sync[0], start};
   end

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
         capture_en <= 1'b0;
      else if (wr_ptr == capture_pkg::FILL_WORDS)
         capture_en <= 1'b0;   // memory is full, no more samples taken in
      else if (start_sync[1])
         capture_en <= 1'b1;
   end

   always_ff @(posedge write_clk)
   begin
      if (issue_write)
      begin
         cmd_op      <= capture_pkg::MEM_WRITE;
         cmd_address <= wr_ptr;
         cmd_wdata   <= aq_rd_data;
      end
      else if (issue_read)
      begin
         cmd_op      <= capture_pkg::MEM_READ;
         cmd_address <= rd_ptr;
      end
   end

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         state      <= capture_pkg::CAPTURE_WAIT;
         cmd_enable <= 1'b0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         blk_cnt    <= '0;
         in_flight  <= '0;
         filled     <= 1'b0;
         done       <= 1'b0;
      end
      else
      begin
         // cmd_ready was high when issued, so the command goes on the next edge
         cmd_enable <= issue_write || issue_read;

         if (issue_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (issue_read)
            rd_ptr <= rd_ptr + 1'b1;

         case ({issue_read, rd_valid})
            2'b10:   in_flight <= in_flight + 1'b1;
            2'b01:   in_flight <= in_flight - 1'b1;
            default: in_flight <= in_flight;
         endcase

         case (state)
            capture_pkg::CAPTURE_WAIT:
            begin
               if (wr_ptr == capture_pkg::FILL_WORDS)
               begin
                  filled <= 1'b1;
                  state  <= capture_pkg::PLAYBACK;
               end
               else if (aq_count >= capture_pkg::BLOCK_LEN)
                  state <= capture_pkg::CAPTURE_MOVE;
            end
            capture_pkg::CAPTURE_MOVE:
            begin
               if (issue_write)
               begin
                  if (blk_cnt == capture_pkg::BLOCK_LEN - 1)
                  begin
                     blk_cnt <= '0;
                     state   <= capture_pkg::CAPTURE_WAIT;
                  end
                  else
                     blk_cnt <= blk_cnt + 1'b1;
               end
            end
            capture_pkg::PLAYBACK:
            begin
               if (play_over)
               begin
                  done  <= 1'b1;
                  state <= capture_pkg::FINISHED;
               end
               else if (tx_count >= capture_pkg::TX_HIGH)
                  state <= capture_pkg::PLAYBACK_HOLD;
            end
            capture_pkg::PLAYBACK_HOLD:
            begin
               if (play_over)
               begin
                  done  <= 1'b1;
                  state <= capture_pkg::FINISHED;
               end
               else if (tx_count < capture_pkg::TX_LOW)
                  state <= capture_pkg::PLAYBACK;
            end
            capture_pkg::FINISHED:
               state <= capture_pkg::FINISHED;   // no restart after a run
            default:
               state <= capture_pkg::CAPTURE_WAIT;
         endcase
      end
   end

   // a registered command must find the memory still ready
   a_cmd_ready: assert property (@(posedge write_clk) disable iff (rst)
      cmd_enable |-> cmd_ready)
      else $error("command issued while memory busy");

   a_in_flight: assert property (@(posedge write_clk) disable iff (rst)
      in_flight <= capture_pkg::MEM_READ_LAT + 1)
      else $error("too many reads in flight");

endmodule

// File: hdl/sample_fifo.sv
module sample_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                                write_clk,
   input  logic                                rst,

   input  logic                                wr_valid,
   output logic                                wr_ready,
   input  logic [capture_pkg::SAMPLE_W-1:0]    wr_data,

   output logic                                rd_valid,
   input  logic                                rd_ready,
   output logic [capture_pkg::SAMPLE_W-1:0]    rd_data,

   output logic [$clog2(DEPTH+1)-1:0]          count
);

   logic [capture_pkg::SAMPLE_W-1:0] mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]         wr_ptr;
   logic [$clog2(DEPTH)-1:0]         rd_ptr;
   logic                             push;
   logic                             pop;

   assign wr_ready = (count < DEPTH);
   assign rd_valid = (count != 0);
   assign rd_data  = mem[rd_ptr];   // first-word fall-through from the array

   assign push = wr_valid && wr_ready;
   assign pop  = rd_valid && rd_ready;

   always_ff @(posedge write_clk)
   begin
      if (push)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;

         // a push and a pop on the same edge leave the fill level alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_count_bound: assert property (@(posedge write_clk) disable iff (rst)
      count <= DEPTH)
      else $error("sample_fifo count above depth");

endmodule

// File: hdl/capture_pkg.sv
package capture_pkg;

   localparam int SAMPLE_W     = 16;
   localparam int ADDR_W       = 7;   // wide enough to hold FILL_WORDS itself
   localparam int BLOCK_LEN    = 8;
   localparam int FILL_WORDS   = 64;

   localparam int AQ_DEPTH     = 32;
   localparam int TX_DEPTH     = 16;

   // playback hysteresis on the transmit fill level
   localparam int TX_HIGH      = 12;
   localparam int TX_LOW       = 4;

   localparam int MEM_READ_LAT = 2;

   // derived widths for the count ports and the scheduler counters
   localparam int AQ_CNT_W     = $clog2(AQ_DEPTH + 1);
   localparam int TX_CNT_W     = $clog2(TX_DEPTH + 1);
   localparam int BLK_CNT_W    = $clog2(BLOCK_LEN);
   localparam int FLIGHT_W     = $clog2(MEM_READ_LAT + 2);

   typedef enum logic [2:0]
   {
      CAPTURE_WAIT,
      CAPTURE_MOVE,
      PLAYBACK,
      PLAYBACK_HOLD,
      FINISHED
   } sched_state_t;

   typedef enum logic
   {
      MEM_READ,
      MEM_WRITE
   } mem_op_t;

endpackage
